// File: Bender.yml
package:
  name: ce_tx

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ce_tx_pkg.sv
      - verilog/ce_tx_ifs.sv
      - verilog/ce_tx_regs.sv
      - verilog/ce_tx_addr_chan.sv
      - verilog/ce_tx_data_chan.sv
      - verilog/ce_tx_resp_chan.sv
      - verilog/ce_tx_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - testbench
    files:
      - testbench/tb_ce_tx.sv

// File: all.f
+incdir+verilog
+incdir+testbench
verilog/ce_tx_pkg.sv
verilog/ce_tx_ifs.sv
verilog/ce_tx_regs.sv
verilog/ce_tx_addr_chan.sv
verilog/ce_tx_data_chan.sv
verilog/ce_tx_resp_chan.sv
verilog/ce_tx_top.sv
testbench/tb_ce_tx.sv

// File: testbench/tb_ce_tx_tasks.svh
// ------------------------------
// Directed tests included inside tb_ce_tx
// Tests share one DUT and run in order
// ------------------------------
`ifndef TB_CE_TX_TASKS_SVH
`define TB_CE_TX_TASKS_SVH

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
   if (exp !== act)
   begin
      err_cnt++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic check_beat(input string name, input beat_t exp, input beat_t act);
   if (exp !== act)
   begin
      err_cnt++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (exp !== act)
   begin
      err_cnt++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
   if (exp !== act)
   begin
      err_cnt++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
   end
endtask

// ------------------------------
// APB master
// ------------------------------
task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b1;
   paddr   <= addr;
   pwdata  <= data;
   @(posedge clk);
   penable <= 1'b1;
   @(posedge clk);
   check_bit("apb write pready", 1'b1, pready);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic slv);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b0;
   paddr   <= addr;
   @(posedge clk);
   penable <= 1'b1;
   @(posedge clk);
   data    = prdata;   // Still the access phase here
   slv     = pslverr;
   check_bit("apb read pready", 1'b1, pready);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

// Poll CTRL until done or err shows up
task automatic wait_end(output logic done_b, output logic err_b);
   logic [31:0] rd;
   logic        slv;
   rd = '0;
   while (rd[2:1] == 2'b00)
      apb_read(`CE_REG_CTRL, rd, slv);
   done_b = rd[1];
   err_b  = rd[2];
endtask

task automatic run_xfer(input addr_t addr, input int nbeats, input int log2, input beat_t base,
                        input int bad, output logic done_b, output logic err_b);
   @(posedge clk);
   load_base <= base;
   load_n    <= nbeats;
   bad_burst <= bad;
   load_req  <= 1'b1;
   @(posedge clk);
   load_req  <= 1'b0;
   apb_write(`CE_REG_HPS_ADDR, addr);
   apb_write(`CE_REG_XFR_SIZE, 32'(nbeats * 8));
   apb_write(`CE_REG_BURST_LOG2, 32'(log2));
   apb_write(`CE_REG_CTRL, 32'd1);
   wait_end(done_b, err_b);
endtask

// Expected bursts, data order and wlast from the transfer setup
task automatic check_bursts(input string name, input addr_t addr, input int nbeats,
                            input int log2, input beat_t base);
   int per;
   int nb;
   int left;
   int len;
   per  = 1 << log2;
   nb   = (nbeats + per - 1) / per;
   left = nbeats;
   check_word({name, " AW count"}, nb, aw_addr_q.size());
   check_word({name, " B count"}, nb, b_resp_q.size());
   for (int i = 0; i < nb && i < aw_addr_q.size(); i++)
   begin
      len = (left < per) ? left : per;
      check_addr({name, " awaddr"}, addr + addr_t'(i * per * 8), aw_addr_q[i]);
      check_word({name, " awlen"}, len - 1, aw_len_q[i]);
      left -= len;
   end
   check_word({name, " W count"}, nbeats, w_data_q.size());
   for (int k = 0; k < nbeats && k < w_data_q.size(); k++)
   begin
      check_beat({name, " wdata"}, base + beat_t'(k), w_data_q[k]);
      check_bit({name, " wstrb"}, 1'b1, &w_strb_q[k]);
      check_bit({name, " wlast"}, ((k + 1) % per == 0) || (k == nbeats - 1), w_last_q[k]);
   end
endtask

// ------------------------------
// Tests
// ------------------------------
task automatic test_regs();
   logic [31:0] rd;
   logic        slv;
   apb_write(`CE_REG_HPS_ADDR, 32'h1234_5678);
   apb_read(`CE_REG_HPS_ADDR, rd, slv);
   check_addr("regs hps_addr", 32'h1234_5678, rd);
   check_bit("regs pslverr mapped", 1'b0, slv);
   apb_write(`CE_REG_XFR_SIZE, 32'h0000_0148);
   apb_read(`CE_REG_XFR_SIZE, rd, slv);
   check_word("regs xfr_size", 32'h148, rd);
   apb_write(`CE_REG_BURST_LOG2, 32'd3);
   apb_read(`CE_REG_BURST_LOG2, rd, slv);
   check_word("regs burst_log2", 32'd3, rd);
   apb_write(`CE_REG_CTRL, 32'h7);        // Status bits are read-only
   apb_read(`CE_REG_CTRL, rd, slv);
   check_word("regs ctrl", 32'd1, rd);
   apb_write(`CE_REG_CTRL, 32'd0);        // Engine idles again on an empty FIFO
   apb_read(`CE_REG_CTRL, rd, slv);
   check_word("regs ctrl cleared", 32'd0, rd);
   apb_read(4'h2, rd, slv);
   check_bit("regs pslverr unmapped", 1'b1, slv);
endtask

task automatic test_single();
   logic d;
   logic e;
   run_xfer(32'h2000_0000, 4, 3, 64'ha5a5_0000_0000_0000, 0, d, e);
   check_bit("single done", 1'b1, d);
   check_bit("single err", 1'b0, e);
   check_bursts("single", 32'h2000_0000, 4, 3, 64'ha5a5_0000_0000_0000);
   apb_write(`CE_REG_CTRL, 32'd0);
endtask

task automatic test_multi();
   logic d;
   logic e;
   run_xfer(32'h3000_0100, 37, 3, 64'h3c3c_0000_0000_1000, 0, d, e);  // 4 full and a 5-beat tail
   check_bit("multi done", 1'b1, d);
   check_bit("multi err", 1'b0, e);
   check_bursts("multi", 32'h3000_0100, 37, 3, 64'h3c3c_0000_0000_1000);
   apb_write(`CE_REG_CTRL, 32'd0);
endtask

task automatic test_error();
   logic d;
   logic e;
   run_xfer(32'h4000_0000, 24, 3, 64'h7e7e_0000_0000_2000, 2, d, e);
   check_bit("error err", 1'b1, e);
   check_bit("error done", 1'b0, d);
   repeat (40) @(posedge clk);            // Give a stray AW time to appear
   check_word("error AW count", 2, aw_addr_q.size());
   check_word("error B count", 2, b_resp_q.size());
endtask

task automatic test_clear();
   logic [31:0] rd;
   logic        slv;
   logic        d;
   logic        e;
   apb_write(`CE_REG_CTRL, 32'd0);
   apb_read(`CE_REG_CTRL, rd, slv);
   check_word("clear ctrl", 32'd0, rd);
   run_xfer(32'h5000_0080, 16, 2, 64'h5151_0000_0000_3000, 0, d, e);
   check_bit("clear done", 1'b1, d);
   check_bit("clear err", 1'b0, e);
   check_bursts("clear", 32'h5000_0080, 16, 2, 64'h5151_0000_0000_3000);
   apb_write(`CE_REG_CTRL, 32'd0);
endtask

`endif

// File: testbench/tb_ce_tx.sv
// ------------------------------
// Testbench with a show-ahead FIFO model and a stalling AXI write slave
// FIFO model holds at most 63 beats with all strobes set
// ------------------------------
`timescale 1ns/10ps
`include "ce_tx_defines.svh"

module tb_ce_tx;
   import ce_tx_pkg::*;

   localparam int TIMEOUT_CYCLES = 20000;  // Five tests at worst-case stalls plus margin

   logic                      clk;
   logic                      ce_corereset;
   logic                      psel, penable, pwrite;
   logic [`CE_APB_ADDR_W-1:0] paddr;
   logic [31:0]               pwdata, prdata;
   logic                      pready, pslverr;
   logic                      fifo_empty, fifo_ren;
   logic [`CE_FIFO_CNT_W-1:0] fifo_count;
   beat_t                     fifo_data;
   strb_t                     fifo_strb;
   logic                      awvalid, awready;
   addr_t                     awaddr;
   logic [7:0]                awlen;
   logic [2:0]                awsize;
   logic [1:0]                awburst;
   logic                      wvalid, wready, wlast;
   beat_t                     wdata;
   strb_t                     wstrb;
   logic                      bvalid, bready;
   resp_e                     bresp;

   // FIFO model
   beat_t       mem [0:63];
   logic [6:0]  rd_ptr, wr_ptr, fill_cnt;
   beat_t       next_val;
   int          fill_left;
   logic        load_req;     // Empties FIFO and clears the slave records
   beat_t       load_base;
   int          load_n;

   // Slave records
   int          bad_burst;    // Burst number answered with SLVERR or 0 for none
   int          aw_cnt, wl_cnt, b_cnt;
   addr_t       aw_addr_q[$];
   logic [7:0]  aw_len_q[$];
   beat_t       w_data_q[$];
   strb_t       w_strb_q[$];
   logic        w_last_q[$];
   resp_e       b_resp_q[$];
   int          err_cnt;

   ce_tx_top ce_tx_top_i (
      .clk(clk), .ce_corereset(ce_corereset), .psel(psel), .penable(penable),
      .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .fifo_empty(fifo_empty), .fifo_count(fifo_count),
      .fifo_data(fifo_data), .fifo_strb(fifo_strb), .fifo_ren(fifo_ren),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awlen(awlen),
      .awsize(awsize), .awburst(awburst), .wvalid(wvalid), .wready(wready),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .bvalid(bvalid), .bready(bready),
      .bresp(bresp)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   assign fill_cnt   = wr_ptr - rd_ptr;
   assign fifo_count = fill_cnt[5:0];
   assign fifo_empty = (fill_cnt == 7'd0);
   assign fifo_data  = mem[rd_ptr[5:0]];   // Show-ahead head
   assign fifo_strb  = '1;

   // ------------------------------
   // FIFO model refilled at a random rate
   // ------------------------------
   always @(posedge clk)
   begin
      if (ce_corereset || load_req)
      begin
         rd_ptr    <= '0;
         wr_ptr    <= '0;
         next_val  <= load_base;
         fill_left <= load_req ? load_n : 0;
      end
      else
      begin
         if (fifo_ren)
            rd_ptr <= rd_ptr + 7'd1;
         if (fill_left > 0 && fill_cnt < 7'd63 && ($urandom % 4) != 0)
         begin
            mem[wr_ptr[5:0]] <= next_val;
            wr_ptr           <= wr_ptr + 7'd1;
            next_val         <= next_val + 64'd1;
            fill_left        <= fill_left - 1;
         end
      end
   end

   // ------------------------------
   // Memory-side slave
   // ------------------------------
   always @(posedge clk)
   begin
      if (ce_corereset || load_req)
      begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= OKAY;
         aw_cnt  <= 0;
         wl_cnt  <= 0;
         b_cnt   <= 0;
         aw_addr_q.delete();
         aw_len_q.delete();
         w_data_q.delete();
         w_strb_q.delete();
         w_last_q.delete();
         b_resp_q.delete();
      end
      else
      begin
         awready <= ($urandom % 3) != 0;
         wready  <= ($urandom % 4) != 0;
         if (awvalid && awready)
         begin
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
            aw_cnt <= aw_cnt + 1;
            if (awsize !== 3'd3 || awburst !== 2'b01)
            begin
               err_cnt++;
               $display("Burst %0d was not sent as INCR with 8-byte beats", aw_cnt);
            end
         end
         if (wvalid && wready)
         begin
            w_data_q.push_back(wdata);
            w_strb_q.push_back(wstrb);
            w_last_q.push_back(wlast);
            if (wlast)
               wl_cnt <= wl_cnt + 1;
         end
         // Respond once address and last beat of a burst are both in
         if (bvalid && bready)
         begin
            bvalid <= 1'b0;
            b_cnt  <= b_cnt + 1;
            b_resp_q.push_back(bresp);
         end
         else if (!bvalid && b_cnt < aw_cnt && b_cnt < wl_cnt)
         begin
            bvalid <= 1'b1;
            bresp  <= (b_cnt + 1 == bad_burst) ? SLVERR : OKAY;
         end
      end
   end

   `include "tb_ce_tx_tasks.svh"

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, a transfer never finished", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h80e3_d275));
      err_cnt      = 0;
      ce_corereset = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      awready      = 1'b0;
      wready       = 1'b0;
      bvalid       = 1'b0;
      bresp        = OKAY;
      load_req     = 1'b0;
      load_base    = '0;
      load_n       = 0;
      bad_burst    = 0;
      rd_ptr       = '0;
      wr_ptr       = '0;
      next_val     = '0;
      fill_left    = 0;
      for (int i = 0; i < 64; i++)
         mem[i] = {32'hc0de_0000 | 32'(i), ~32'(i)};
      repeat (10) @(posedge clk);
      ce_corereset <= 1'b0;

      test_regs();
      test_single();
      test_multi();
      test_error();
      test_clear();

      $display("Checks finished with %0d errors", err_cnt);
      if (err_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: verilog/ce_tx_addr_chan.sv
// ----------------------------
// Splits the transfer into INCR bursts with one in flight
// burst_log2 above 4 is not supported
// ----------------------------
`timescale 1ns/10ps
`include "ce_tx_defines.svh"

module ce_tx_addr_chan (
   input  logic                      clk,
   input  logic                      ce_corereset,
   ce_tx_cfg_if.addr                 cfg,
   ce_tx_burst_if.addr               burst,
   input  logic [`CE_FIFO_CNT_W-1:0] fifo_count,
   input  logic                      awready,
   output logic                      awvalid,
   output ce_tx_pkg::addr_t          awaddr,
   output logic [7:0]                awlen,
   output logic [2:0]                awsize,
   output logic [1:0]                awburst
);
   import ce_tx_pkg::*;

   typedef enum logic [1:0] {
      AW_IDLE,
      AW_WAIT_DATA,
      AW_SEND_ADDR,
      AW_WAIT_RESP
   } aw_state_e;

   aw_state_e   state;
   aw_state_e   state_nxt;
   logic        start_q;
   logic        start_rise;
   logic [31:0] total_beats;
   logic [31:0] beat_mask;    // Beats per burst minus one
   logic [31:0] bursts_left;
   beats_t      full_beats;
   beats_t      last_beats;
   beats_t      cur_beats;

   assign start_rise  = cfg.start & ~start_q;
   assign total_beats = cfg.xfr_size >> `CE_BEAT_BYTES_LOG2;
   assign beat_mask   = (32'd1 << cfg.burst_log2) - 32'd1;

   assign burst.final_burst = (bursts_left == 32'd1);
   assign cur_beats         = burst.final_burst ? last_beats : full_beats;
   assign burst.beats       = cur_beats;
   assign burst.issue       = awvalid & awready;

   assign awvalid = (state == AW_SEND_ADDR);
   assign awlen   = {3'b000, cur_beats - 5'd1};
   assign awsize  = 3'(`CE_BEAT_BYTES_LOG2);  // 8 bytes per beat
   assign awburst = 2'b01;                    // INCR

   // ----------------------------
   // Burst planning
   // ----------------------------
   always_ff @(posedge clk)
   begin
      if (ce_corereset)
      begin
         start_q     <= 1'b0;
         bursts_left <= '0;
      end
      else
      begin
         start_q <= cfg.start;
         if (start_rise)
            bursts_left <= (total_beats + beat_mask) >> cfg.burst_log2;  // Rounded up
         else if (burst.issue)
            bursts_left <= bursts_left - 32'd1;
         else if (!cfg.start && state == AW_IDLE)
            bursts_left <= '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_rise)
      begin
         awaddr     <= cfg.hps_addr;
         full_beats <= beats_t'(beat_mask + 32'd1);
         // Partial tail when the beat count is not a whole number of bursts
         last_beats <= ((total_beats & beat_mask) == 32'd0) ? beats_t'(beat_mask + 32'd1)
                                                            : beats_t'(total_beats & beat_mask);
      end
      else if (burst.issue)
      begin
         awaddr <= awaddr + (addr_t'(full_beats) << `CE_BEAT_BYTES_LOG2);
      end
   end

   // ----------------------------
   // Address FSM
   // ----------------------------
   always_ff @(posedge clk)
   begin
      if (ce_corereset)
         state <= AW_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         AW_IDLE      : if (start_rise) state_nxt = AW_WAIT_DATA;
         AW_WAIT_DATA :
         begin
            if (!cfg.start)
               state_nxt = AW_IDLE;
            else if (fifo_count >= {1'b0, cur_beats} && !cfg.err)
               state_nxt = AW_SEND_ADDR;
         end
         AW_SEND_ADDR : if (awready) state_nxt = burst.final_burst ? AW_IDLE : AW_WAIT_RESP;
         AW_WAIT_RESP :
         begin
            if (cfg.err)
               state_nxt = AW_IDLE;          // Engine stops on a bad response
            else if (burst.complete)
               state_nxt = AW_WAIT_DATA;
         end
         default      : state_nxt = AW_IDLE;
      endcase
   end

   // Address held until accepted
   assert property (@(posedge clk) disable iff (ce_corereset)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

endmodule

// File: verilog/ce_tx_data_chan.sv
// ----------------------------
// Streams the FIFO head onto W once a burst is issued
// FIFO must be show-ahead
// ----------------------------
`timescale 1ns/10ps

module ce_tx_data_chan (
   input  logic              clk,
   input  logic              ce_corereset,
   ce_tx_burst_if.data       burst,
   input  logic              fifo_empty,
   input  ce_tx_pkg::beat_t  fifo_data,
   input  ce_tx_pkg::strb_t  fifo_strb,
   input  logic              wready,
   output logic              fifo_ren,
   output logic              wvalid,
   output ce_tx_pkg::beat_t  wdata,
   output ce_tx_pkg::strb_t  wstrb,
   output logic              wlast
);
   import ce_tx_pkg::*;

   logic   in_burst;
   logic   w_hs;
   beats_t beat_cnt;      // Beats sent in this burst
   beats_t burst_beats;   // Captured at issue

   assign wvalid   = in_burst & ~fifo_empty;
   assign wdata    = fifo_data;                 // Straight from the FIFO head
   assign wstrb    = fifo_strb;
   assign wlast    = wvalid & (beat_cnt == burst_beats - 5'd1);
   assign w_hs     = wvalid & wready;
   assign fifo_ren = w_hs;                      // Pop with each accepted beat

   always_ff @(posedge clk)
   begin
      if (ce_corereset)
      begin
         in_burst <= 1'b0;
         beat_cnt <= '0;
      end
      else if (burst.issue)
      begin
         in_burst <= 1'b1;
         beat_cnt <= '0;
      end
      else if (w_hs)
      begin
         in_burst <= ~wlast;
         beat_cnt <= beat_cnt + 5'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (burst.issue)
         burst_beats <= burst.beats;
   end

   // Next burst only after the last beat of this one
   assert property (@(posedge clk) disable iff (ce_corereset) burst.issue |-> !in_burst);

   // Beat held under back-pressure
   assert property (@(posedge clk) disable iff (ce_corereset)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

endmodule

// File: verilog/ce_tx_defines.svh
// ----------------------------
// Widths for the 64-bit data path and APB register offsets
// Transfer size must be a nonzero multiple of 8 bytes
// ----------------------------
`ifndef CE_TX_DEFINES_SVH
`define CE_TX_DEFINES_SVH

`define CE_ADDR_W           32
`define CE_DATA_W           64
`define CE_STRB_W           8
`define CE_BEAT_BYTES_LOG2  3
`define CE_FIFO_CNT_W       6
`define CE_APB_ADDR_W       4

`define CE_REG_HPS_ADDR     4'h0  // Destination address
`define CE_REG_XFR_SIZE     4'h4  // Bytes to move
`define CE_REG_BURST_LOG2   4'h8  // Beats per burst as log2, 0 to 4
`define CE_REG_CTRL         4'hC  // Start bit 0 with done bit 1 and err bit 2
`endif

// File: verilog/ce_tx_ifs.sv
// ----------------------------
// Setup and burst handoff between the engine blocks
// ----------------------------
`timescale 1ns/10ps

// Register setup and status
interface ce_tx_cfg_if;
   import ce_tx_pkg::*;

   logic        start;
   addr_t       hps_addr;
   logic [31:0] xfr_size;     // Bytes
   logic [3:0]  burst_log2;
   logic        done;
   logic        err;          // Sticky until start clears

   modport regs (output start, hps_addr, xfr_size, burst_log2,
                 input  done, err);
   modport addr (input  start, hps_addr, xfr_size, burst_log2, err);
   modport resp (input  start,
                 output done, err);
endinterface

// Per-burst events from the address channel
interface ce_tx_burst_if;
   import ce_tx_pkg::*;

   logic   issue;        // Pulse on AW acceptance
   beats_t beats;        // Length of the burst being planned
   logic   final_burst;  // Last burst of the transfer
   logic   complete;     // Pulse on OKAY of a non-final burst

   modport addr (output issue, beats, final_burst,
                 input  complete);
   modport data (input  issue, beats);
   modport resp (input  issue, final_burst,
                 output complete);
endinterface

// File: verilog/ce_tx_pkg.sv
// ----------------------------
// Types sized from the defines header
// ----------------------------
`include "ce_tx_defines.svh"

package ce_tx_pkg;

   typedef logic [`CE_ADDR_W-1:0] addr_t;   // Byte address
   typedef logic [`CE_DATA_W-1:0] beat_t;   // One data beat
   typedef logic [`CE_STRB_W-1:0] strb_t;   // Byte enables of a beat

   // Holds up to 16 beats per burst
   typedef logic [4:0] beats_t;

   // ----------------------------
   // Write response codes
   // ----------------------------
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

endpackage

// File: verilog/ce_tx_regs.sv
// ----------------------------
// APB slave with zero wait states
// Misaligned offsets answer with pslverr
// ----------------------------
`timescale 1ns/10ps
`include "ce_tx_defines.svh"

module ce_tx_regs (
   input  logic                      clk,
   input  logic                      ce_corereset,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [`CE_APB_ADDR_W-1:0] paddr,
   input  logic [31:0]               pwdata,
   output logic [31:0]               prdata,
   output logic                      pslverr,
   ce_tx_cfg_if.regs                 cfg
);

   logic addr_hit;
   logic wr_en;

   assign wr_en   = psel & penable & pwrite & addr_hit;  // Access phase
   assign pslverr = psel & penable & ~addr_hit;

   // ----------------------------
   // Read mux and offset decode
   // ----------------------------
   always_comb
   begin
      prdata   = '0;
      addr_hit = 1'b1;
      case (paddr)
         `CE_REG_HPS_ADDR   : prdata = cfg.hps_addr;
         `CE_REG_XFR_SIZE   : prdata = cfg.xfr_size;
         `CE_REG_BURST_LOG2 : prdata = {28'd0, cfg.burst_log2};
         `CE_REG_CTRL       : prdata = {29'd0, cfg.err, cfg.done, cfg.start};
         default            : addr_hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (ce_corereset)
      begin
         cfg.start      <= 1'b0;
         cfg.hps_addr   <= '0;
         cfg.xfr_size   <= '0;
         cfg.burst_log2 <= '0;
      end
      else if (wr_en)
      begin
         case (paddr)
            `CE_REG_HPS_ADDR   : cfg.hps_addr   <= pwdata;
            `CE_REG_XFR_SIZE   : cfg.xfr_size   <= pwdata;
            `CE_REG_BURST_LOG2 : cfg.burst_log2 <= pwdata[3:0];
            `CE_REG_CTRL       : cfg.start      <= pwdata[0];  // Done and err ignore writes
            default            : ;
         endcase
      end
   end

   // Access phase must follow a setup phase
   assert property (@(posedge clk) disable iff (ce_corereset)
      penable |-> $past(psel));

endmodule

// File: verilog/ce_tx_resp_chan.sv
// ----------------------------
// Judges each write response
// Only OKAY counts as success
// ----------------------------
`timescale 1ns/10ps

module ce_tx_resp_chan (
   input  logic              clk,
   input  logic              ce_corereset,
   ce_tx_cfg_if.resp         cfg,
   ce_tx_burst_if.resp       burst,
   input  logic              bvalid,
   input  ce_tx_pkg::resp_e  bresp,
   output logic              bready
);
   import ce_tx_pkg::*;

   logic b_hs;
   logic b_ok;
   logic final_q;   // Outstanding burst is the last one

   assign b_hs           = bvalid & bready;
   assign b_ok           = (bresp == OKAY);
   assign burst.complete = b_hs & b_ok & ~final_q;

   always_ff @(posedge clk)
   begin
      if (ce_corereset)
         bready <= 1'b0;
      else if (burst.issue)
         bready <= 1'b1;
      else if (b_hs)
         bready <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (burst.issue)
         final_q <= burst.final_burst;
   end

   // ----------------------------
   // Status
   // ----------------------------
   always_ff @(posedge clk)
   begin
      if (ce_corereset || !cfg.start)
      begin
         cfg.done <= 1'b0;
         cfg.err  <= 1'b0;
      end
      else if (b_hs)
      begin
         if (!b_ok)
            cfg.err <= 1'b1;        // Sticky
         else if (final_q)
            cfg.done <= 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (ce_corereset) !(cfg.done && cfg.err));

endmodule

// File: verilog/ce_tx_top.sv
// ----------------------------
// Copy-engine write master with APB setup
// One burst outstanding and pready tied high
// ----------------------------
`timescale 1ns/10ps
`include "ce_tx_defines.svh"

module ce_tx_top (
   input  logic                      clk,
   input  logic                      ce_corereset,
   // APB slave
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [`CE_APB_ADDR_W-1:0] paddr,
   input  logic [31:0]               pwdata,
   output logic [31:0]               prdata,
   output logic                      pready,
   output logic                      pslverr,
   // Completion FIFO
   input  logic                      fifo_empty,
   input  logic [`CE_FIFO_CNT_W-1:0] fifo_count,
   input  ce_tx_pkg::beat_t          fifo_data,
   input  ce_tx_pkg::strb_t          fifo_strb,
   output logic                      fifo_ren,
   // Write address channel
   output logic                      awvalid,
   input  logic                      awready,
   output ce_tx_pkg::addr_t          awaddr,
   output logic [7:0]                awlen,
   output logic [2:0]                awsize,
   output logic [1:0]                awburst,
   // Write data channel
   output logic                      wvalid,
   input  logic                      wready,
   output ce_tx_pkg::beat_t          wdata,
   output ce_tx_pkg::strb_t          wstrb,
   output logic                      wlast,
   // Write response channel
   input  logic                      bvalid,
   output logic                      bready,
   input  ce_tx_pkg::resp_e          bresp
);

   ce_tx_cfg_if   cfg_if ();
   ce_tx_burst_if burst_if ();

   assign pready = 1'b1;  // Zero wait states

   ce_tx_regs regs_i (
      .clk(clk), .ce_corereset(ce_corereset), .psel(psel), .penable(penable),
      .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
      .pslverr(pslverr), .cfg(cfg_if.regs)
   );

   ce_tx_addr_chan addr_chan_i (
      .clk(clk), .ce_corereset(ce_corereset), .cfg(cfg_if.addr),
      .burst(burst_if.addr), .fifo_count(fifo_count), .awready(awready),
      .awvalid(awvalid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
      .awburst(awburst)
   );

   ce_tx_data_chan data_chan_i (
      .clk(clk), .ce_corereset(ce_corereset), .burst(burst_if.data),
      .fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_strb(fifo_strb),
      .wready(wready), .fifo_ren(fifo_ren), .wvalid(wvalid), .wdata(wdata),
      .wstrb(wstrb), .wlast(wlast)
   );

   ce_tx_resp_chan resp_chan_i (
      .clk(clk), .ce_corereset(ce_corereset), .cfg(cfg_if.resp),
      .burst(burst_if.resp), .bvalid(bvalid), .bresp(bresp), .bready(bready)
   );

endmodule
